//--- common/icache_defs.svh
// Instruction cache sizing macros
// Widths and depths shared by all cache blocks
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// Fetch address width
`define ICACHE_ADDR_W 32
// Request id width
`define ICACHE_ID_W 8
// Instruction word width
`define ICACHE_ILEN 32
// Line and central memory data width, four words
`define ICACHE_LINE_W 128
// Number of direct-mapped lines
`define ICACHE_LINES 16
// Depth of the request and completion FIFOs
`define ICACHE_OSTDREQ 4

`endif

//--- common/icache_pkg.sv
// Instruction cache types
// Address decode, fetch request payload and sequencer states
`include "icache_defs.svh"

package icache_pkg;

    // Field view of a fetch address
    typedef struct packed {
        logic [23:0] tag;
        logic [3:0]  index;
        logic [1:0]  word;
        logic [1:0]  offset;
    } addr_fields_t;

    // One address word, seen flat or split into line fields
    typedef union packed {
        logic [`ICACHE_ADDR_W-1:0] flat;
        addr_fields_t              f;
    } icache_addr_u;

    typedef struct packed {
        icache_addr_u            addr;
        logic [`ICACHE_ID_W-1:0] id;
        logic [2:0]              prot;
    } fetch_req_t;

    // Lookup sequencer, replays a request after its refill
    typedef enum logic [1:0] {
        seq_idle  = 2'd0,
        seq_load  = 2'd1,
        seq_fetch = 2'd2
    } seq_state_t;

endpackage

//--- common/icache_ifs.sv
// Instruction cache internal buses
// Lookup bus from the fetcher and fill bus to the refill controller
`timescale 1ns/1ps
`include "icache_defs.svh"

////////////////////////////////////////////////////////////
// Lookup bus, hit and miss come one clock after ren
////////////////////////////////////////////////////////////
interface cache_rd_if
    import icache_pkg::*;
();
    logic                     ren;
    fetch_req_t               req;
    logic [`ICACHE_ILEN-1:0]  rdata;
    logic                     hit;
    logic                     miss;

    modport fetcher (
        output ren, req,
        input  rdata, hit, miss
    );

    modport lines (
        input  ren, req,
        output rdata, hit, miss
    );
endinterface

////////////////////////////////////////////////////////////
// Miss notification and full-line write back
////////////////////////////////////////////////////////////
interface cache_fill_if
    import icache_pkg::*;
();
    logic                       miss_req;
    icache_addr_u               miss_addr;
    logic                       wen;
    icache_addr_u               waddr;
    logic [`ICACHE_LINE_W-1:0]  wdata;

    modport lines (
        output miss_req, miss_addr,
        input  wen, waddr, wdata
    );

    modport refill (
        input  miss_req, miss_addr,
        output wen, waddr, wdata
    );
endinterface

//--- hw/icache_scfifo.sv
// Single-clock FIFO with flush, full, almost-full and empty flags
// Head word is either combinational (pass-through) or registered
`timescale 1ns/1ps

module icache_scfifo #(
    parameter int PASS_THRU  = 0,
    parameter int ADDR_WIDTH = 2,
    parameter int DATA_WIDTH = 8
) (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  flush,
    input  logic [DATA_WIDTH-1:0] data_in,
    input  logic                  push,
    output logic                  full,
    output logic                  afull,
    output logic [DATA_WIDTH-1:0] data_out,
    input  logic                  pull,
    output logic                  empty
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    // Pointers carry one extra wrap bit
    logic [ADDR_WIDTH:0]   wr_ptr;
    logic [ADDR_WIDTH:0]   rd_ptr;
    logic [ADDR_WIDTH:0]   rd_nxt;
    logic [ADDR_WIDTH:0]   count;
    logic                  do_push;

    assign count   = wr_ptr - rd_ptr;
    assign empty   = (wr_ptr == rd_ptr);
    // Top bit of the count is only set at DEPTH
    assign full    = count[ADDR_WIDTH];
    assign afull   = (count == (ADDR_WIDTH + 1)'(DEPTH - 1));
    assign do_push = push && !full;
    assign rd_nxt  = rd_ptr + (ADDR_WIDTH + 1)'(pull && !empty);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            rd_ptr <= rd_nxt;
        end
    end

    always_ff @(posedge aclk) begin
        if (do_push) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= data_in;
        end
    end

    if (PASS_THRU != 0) begin : g_pass
        assign data_out = mem[rd_ptr[ADDR_WIDTH-1:0]];
    end else begin : g_reg
        logic [DATA_WIDTH-1:0] head_q;
        // Next head word, bypassing a write into the slot that becomes head
        always_ff @(posedge aclk) begin
            if (do_push && (wr_ptr == rd_nxt)) begin
                head_q <= data_in;
            end else begin
                head_q <= mem[rd_nxt[ADDR_WIDTH-1:0]];
            end
        end
        assign data_out = head_q;
    end

    a_no_push_full: assert property (@(posedge aclk) disable iff (!aresetn)
        !(push && full));

endmodule

//--- hw/block_fetcher/icache_block_fetcher.sv
// Block fetcher of the instruction cache
// Queues requests, sequences lookups, replays misses after refill
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_block_fetcher
    import icache_pkg::*;
(
    input  logic                     aclk,
    input  logic                     aresetn,
    input  logic                     flush_reqs,
    input  logic                     flush_blocks,
    output logic                     pending_rd,
    input  logic                     mst_arvalid,
    output logic                     mst_arready,
    input  fetch_req_t               mst_req,
    output logic                     mst_rvalid,
    input  logic                     mst_rready,
    output logic [`ICACHE_ID_W-1:0]  mst_rid,
    output logic [`ICACHE_ILEN-1:0]  mst_rdata,
    cache_rd_if.fetcher              cache,
    input  logic                     cache_writing
);

    localparam int FIFO_AW = $clog2(`ICACHE_OSTDREQ);

    seq_state_t seq_state;
    fetch_req_t head_req;
    // Request of the lookup in flight, replayed after a miss
    fetch_req_t req_q;
    logic       flush;
    logic       hold_sel;
    logic       rac_full;
    logic       rac_empty;
    logic       pull_rac;
    logic       rdc_full;
    logic       rdc_afull;
    logic       rdc_empty;
    logic       push_rdc;

    assign flush = flush_reqs || flush_blocks;

    ////////////////////////////////////////////////////////////
    // Request buffering
    ////////////////////////////////////////////////////////////

    assign mst_arready = !rac_full;

    icache_scfifo #(
        .PASS_THRU  (1),
        .ADDR_WIDTH (FIFO_AW),
        .DATA_WIDTH ($bits(fetch_req_t))
    ) rac_fifo (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .flush    (flush),
        .data_in  (mst_req),
        .push     (mst_arvalid && mst_arready),
        .full     (rac_full),
        .afull    (),
        .data_out (head_req),
        .pull     (pull_rac),
        .empty    (rac_empty)
    );

    // No new lookup while a miss is handled or completions may overflow
    assign pull_rac = !cache.miss && (seq_state == seq_idle) && !flush
                      && !(rdc_full || rdc_afull);

    ////////////////////////////////////////////////////////////
    // Lookup steering
    ////////////////////////////////////////////////////////////

    // Keep the missed request on the bus until its replay
    assign hold_sel  = (cache.miss || (seq_state != seq_idle)) && !flush;
    assign cache.req = hold_sel ? req_q : head_req;
    assign cache.ren = (!rac_empty && pull_rac) || ((seq_state == seq_fetch) && !flush);

    always_ff @(posedge aclk) begin
        req_q <= cache.req;
    end

    ////////////////////////////////////////////////////////////
    // Completion channel
    ////////////////////////////////////////////////////////////

    assign push_rdc   = cache.hit && !flush;
    assign mst_rvalid = !rdc_empty;

    icache_scfifo #(
        .PASS_THRU  (0),
        .ADDR_WIDTH (FIFO_AW),
        .DATA_WIDTH (`ICACHE_ID_W + `ICACHE_ILEN)
    ) rdc_fifo (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .flush    (flush),
        .data_in  ({req_q.id, cache.rdata}),
        .push     (push_rdc),
        .full     (rdc_full),
        .afull    (rdc_afull),
        .data_out ({mst_rid, mst_rdata}),
        .pull     (mst_rready),
        .empty    (rdc_empty)
    );

    ////////////////////////////////////////////////////////////
    // Sequencer and outstanding refill flag
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            seq_state <= seq_idle;
        end else if (flush) begin
            seq_state <= seq_idle;
        end else begin
            case (seq_state)
                seq_idle: if (cache.miss) seq_state <= seq_load;
                // Line lands in the store on the wen cycle
                seq_load: if (cache_writing) seq_state <= seq_fetch;
                default: seq_state <= seq_idle;
            endcase
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            pending_rd <= 1'b0;
        end else if ((seq_state == seq_idle) && cache.miss && !flush) begin
            pending_rd <= 1'b1;
        end else if (cache_writing) begin
            pending_rd <= 1'b0;
        end
    end

    a_hit_miss_excl: assert property (@(posedge aclk) disable iff (!aresetn)
        !(cache.hit && cache.miss));

endmodule

//--- hw/cache_lines/icache_lines.sv
// Direct-mapped line store of the instruction cache
// Registered tag lookup, full-line refill write and invalidate-all
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_lines
    import icache_pkg::*;
(
    input  logic          aclk,
    input  logic          aresetn,
    input  logic          flush_blocks,
    cache_rd_if.lines     rd,
    cache_fill_if.lines   fill
);

    logic [`ICACHE_LINES-1:0]  valid;
    logic [23:0]               tag_mem  [`ICACHE_LINES];
    logic [`ICACHE_LINE_W-1:0] data_mem [`ICACHE_LINES];
    logic [`ICACHE_LINE_W-1:0] line;
    logic                      tag_match;
    logic                      hit_q;
    logic                      miss_q;

    // Field view of the incoming address
    assign line      = data_mem[rd.req.addr.f.index];
    assign tag_match = valid[rd.req.addr.f.index]
                       && (tag_mem[rd.req.addr.f.index] == rd.req.addr.f.tag);

    ////////////////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            hit_q  <= 1'b0;
            miss_q <= 1'b0;
        end else begin
            hit_q  <= rd.ren && tag_match;
            miss_q <= rd.ren && !tag_match;
        end
    end

    // Word select picks one 32-bit slice of the line
    always_ff @(posedge aclk) begin
        if (rd.ren) begin
            rd.rdata       <= line[rd.req.addr.f.word*`ICACHE_ILEN +: `ICACHE_ILEN];
            fill.miss_addr <= rd.req.addr;
        end
    end

    assign rd.hit        = hit_q;
    assign rd.miss       = miss_q;
    assign fill.miss_req = miss_q;

    ////////////////////////////////////////////////////////////
    // Refill and invalidate
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            valid <= '0;
        end else if (flush_blocks) begin
            valid <= '0;
        end else if (fill.wen) begin
            valid[fill.waddr.f.index] <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (fill.wen) begin
            tag_mem[fill.waddr.f.index]  <= fill.waddr.f.tag;
            data_mem[fill.waddr.f.index] <= fill.wdata;
        end
    end

endmodule

//--- hw/icache_refill.sv
// Refill controller of the instruction cache
// Reads a missed line from central memory and writes it to the store
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_refill
    import icache_pkg::*;
(
    input  logic                       aclk,
    input  logic                       aresetn,
    cache_fill_if.refill               fill,
    output logic                       mem_arvalid,
    input  logic                       mem_arready,
    output logic [`ICACHE_ADDR_W-1:0]  mem_araddr,
    input  logic                       mem_rvalid,
    input  logic [`ICACHE_LINE_W-1:0]  mem_rdata
);

    // Refill outstanding, from miss to returned line
    logic         busy;
    icache_addr_u line_addr;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            busy        <= 1'b0;
            mem_arvalid <= 1'b0;
            fill.wen    <= 1'b0;
        end else begin
            fill.wen <= 1'b0;
            if (!busy) begin
                if (fill.miss_req) begin
                    busy        <= 1'b1;
                    mem_arvalid <= 1'b1;
                end
            end else begin
                // Address held until the memory takes it
                if (mem_arready) mem_arvalid <= 1'b0;
                if (mem_rvalid) begin
                    busy     <= 1'b0;
                    fill.wen <= 1'b1;
                end
            end
        end
    end

    // Line-aligned address, word select and byte offset cleared
    always_ff @(posedge aclk) begin
        if (!busy && fill.miss_req) begin
            line_addr.flat <= {fill.miss_addr.flat[`ICACHE_ADDR_W-1:4], 4'b0000};
        end
        if (mem_rvalid) begin
            fill.wdata <= mem_rdata;
        end
    end

    assign mem_araddr = line_addr.flat;
    assign fill.waddr = line_addr;

    a_rvalid_busy: assert property (@(posedge aclk) disable iff (!aresetn)
        mem_rvalid |-> busy);

endmodule

//--- hw/icache_top.sv
// Instruction cache subsystem top level
// Joins the block fetcher, the line store and the refill controller
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_top
    import icache_pkg::*;
(
    input  logic                       aclk,
    input  logic                       aresetn,
    input  logic                       flush_reqs,
    input  logic                       flush_blocks,
    output logic                       pending_rd,
    // Control unit side
    input  logic                       mst_arvalid,
    output logic                       mst_arready,
    input  logic [`ICACHE_ADDR_W-1:0]  mst_araddr,
    input  logic [`ICACHE_ID_W-1:0]    mst_arid,
    input  logic [2:0]                 mst_arprot,
    output logic                       mst_rvalid,
    input  logic                       mst_rready,
    output logic [`ICACHE_ID_W-1:0]    mst_rid,
    output logic [`ICACHE_ILEN-1:0]    mst_rdata,
    output logic [1:0]                 mst_rresp,
    // Central memory side
    output logic                       mem_arvalid,
    input  logic                       mem_arready,
    output logic [`ICACHE_ADDR_W-1:0]  mem_araddr,
    input  logic                       mem_rvalid,
    input  logic [`ICACHE_LINE_W-1:0]  mem_rdata
);

    fetch_req_t   mst_req;
    cache_rd_if   rd_bus ();
    cache_fill_if fill_bus ();

    assign mst_req.addr.flat = mst_araddr;
    assign mst_req.id        = mst_arid;
    assign mst_req.prot      = mst_arprot;
    // Always OKAY
    assign mst_rresp = 2'b00;

    icache_block_fetcher u_fetcher (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .flush_reqs    (flush_reqs),
        .flush_blocks  (flush_blocks),
        .pending_rd    (pending_rd),
        .mst_arvalid   (mst_arvalid),
        .mst_arready   (mst_arready),
        .mst_req       (mst_req),
        .mst_rvalid    (mst_rvalid),
        .mst_rready    (mst_rready),
        .mst_rid       (mst_rid),
        .mst_rdata     (mst_rdata),
        .cache         (rd_bus.fetcher),
        .cache_writing (fill_bus.wen)
    );

    icache_lines u_lines (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .flush_blocks (flush_blocks),
        .rd           (rd_bus.lines),
        .fill         (fill_bus.lines)
    );

    icache_refill u_refill (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .fill        (fill_bus.refill),
        .mem_arvalid (mem_arvalid),
        .mem_arready (mem_arready),
        .mem_araddr  (mem_araddr),
        .mem_rvalid  (mem_rvalid),
        .mem_rdata   (mem_rdata)
    );

endmodule

//--- testbench/icache_tb.sv
// Instruction cache subsystem testbench
// Directed fetch tests against a line memory model and a valid/tag model
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_tb
    import icache_pkg::*;
();

    localparam int          TIMEOUT = 100;
    // Line at index 0 and two lines sharing index 4
    localparam logic [31:0] A_LINE  = 32'h0000_0100;
    localparam logic [31:0] C_ADDR  = 32'h0000_2348;
    localparam logic [31:0] D_ADDR  = 32'h0001_5544;

    logic                       aclk = 1'b0;
    logic                       aresetn;
    logic                       flush_reqs;
    logic                       flush_blocks;
    logic                       pending_rd;
    logic                       mst_arvalid;
    logic                       mst_arready;
    logic [`ICACHE_ADDR_W-1:0]  mst_araddr;
    logic [`ICACHE_ID_W-1:0]    mst_arid;
    logic [2:0]                 mst_arprot;
    logic                       mst_rvalid;
    logic                       mst_rready;
    logic [`ICACHE_ID_W-1:0]    mst_rid;
    logic [`ICACHE_ILEN-1:0]    mst_rdata;
    logic [1:0]                 mst_rresp;
    logic                       mem_arvalid;
    logic                       mem_arready = 1'b0;
    logic [`ICACHE_ADDR_W-1:0]  mem_araddr;
    logic                       mem_rvalid = 1'b0;
    logic [`ICACHE_LINE_W-1:0]  mem_rdata = '0;

    // Memory model state
    integer seed = 32'h0d9e_674c;
    int     mem_reads = 0;
    int     mem_wait = 0;
    logic   mem_busy = 1'b0;
    // Line address the next refill must read
    string                      exp_name = "";
    logic [`ICACHE_ADDR_W-1:0]  exp_line = '0;
    // Reference valid/tag copy of the line store
    logic   model_valid [`ICACHE_LINES];
    logic [23:0] model_tag [`ICACHE_LINES];
    int     pend_seen;

    always #50 aclk = ~aclk;

    icache_top dut (.*);

    ////////////////////////////////////////////////////////////
    // Central memory model
    ////////////////////////////////////////////////////////////

    // Word at each byte address is that address XOR 32'hc0de_0000
    function automatic logic [`ICACHE_LINE_W-1:0] mem_line(input logic [31:0] addr);
        logic [`ICACHE_LINE_W-1:0] line;
        logic [31:0]               base;
        int                        i;
        base = {addr[31:4], 4'b0000};
        for (i = 0; i < 4; i++) begin
            line[i*32 +: 32] = (base + 32'(4 * i)) ^ 32'hc0de_0000;
        end
        return line;
    endfunction

    always @(negedge aclk) begin
        mem_rvalid = 1'b0;
        if (!aresetn) begin
            mem_arready = 1'b0;
            mem_busy    = 1'b0;
        end else if (mem_arready) begin
            // Line follows the address taken on the last rising edge
            check_addr({exp_name, " line address"}, exp_line, mem_araddr);
            mem_arready = 1'b0;
            mem_rvalid  = 1'b1;
            mem_rdata   = mem_line(mem_araddr);
            mem_reads   = mem_reads + 1;
        end else if (mem_arvalid) begin
            // Random accept delay of 1 to 4 cycles
            if (!mem_busy) begin
                mem_busy = 1'b1;
                mem_wait = $unsigned($random(seed)) % 4;
            end
            if (mem_wait == 0) begin
                mem_arready = 1'b1;
                mem_busy    = 1'b0;
            end else begin
                mem_wait = mem_wait - 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Failure reporting and compare tasks
    ////////////////////////////////////////////////////////////

    task automatic end_with_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic wait_failed(input string what);
        seq_state_t st;
        st = dut.u_fetcher.seq_state;
        $display("Timed out waiting for %s, sequencer in %s", what, st.name());
        end_with_failure();
    endtask

    task automatic check_word(input string name, input logic [`ICACHE_ILEN-1:0] exp,
                              input logic [`ICACHE_ILEN-1:0] act);
        if (act !== exp) begin
            $display("Fail %s: data expected %h, actual %h", name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_id(input string name, input logic [`ICACHE_ID_W-1:0] exp,
                            input logic [`ICACHE_ID_W-1:0] act);
        if (act !== exp) begin
            $display("Fail %s: id expected %h, actual %h", name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_addr(input string name, input logic [`ICACHE_ADDR_W-1:0] exp,
                              input logic [`ICACHE_ADDR_W-1:0] act);
        if (act !== exp) begin
            $display("Fail %s: address expected %h, actual %h", name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
            end_with_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Request and completion drivers
    ////////////////////////////////////////////////////////////

    task automatic send_req(input logic [31:0] addr, input logic [`ICACHE_ID_W-1:0] id);
        int n;
        n = 0;
        mst_arvalid = 1'b1;
        mst_araddr  = addr;
        mst_arid    = id;
        while (!mst_arready) begin
            @(negedge aclk);
            n++;
            if (n > TIMEOUT) wait_failed("mst_arready");
        end
        // Taken on the rising edge in between
        @(negedge aclk);
        mst_arvalid = 1'b0;
    endtask

    task automatic recv_resp(input string name, input logic [`ICACHE_ID_W-1:0] exp_id,
                             input logic [`ICACHE_ILEN-1:0] exp_data);
        int n;
        n = 0;
        while (!mst_rvalid) begin
            if (pending_rd) pend_seen = 1;
            @(negedge aclk);
            n++;
            if (n > TIMEOUT) wait_failed("mst_rvalid");
        end
        check_id(name, exp_id, mst_rid);
        check_word(name, exp_data, mst_rdata);
        check_flag({name, " rresp"}, 0, int'(mst_rresp));
        mst_rready = 1'b1;
        @(negedge aclk);
        mst_rready = 1'b0;
    endtask

    // One fetch with its refill predicted from the valid/tag copy
    task automatic read_check(input string name, input logic [31:0] addr,
                              input logic [`ICACHE_ID_W-1:0] id);
        icache_addr_u a;
        int           refill;
        int           reads0;
        a.flat = addr;
        refill = (!model_valid[a.f.index] || model_tag[a.f.index] != a.f.tag) ? 1 : 0;
        model_valid[a.f.index] = 1'b1;
        model_tag[a.f.index]   = a.f.tag;
        reads0    = mem_reads;
        pend_seen = 0;
        exp_name  = name;
        exp_line  = {addr[31:4], 4'b0000};
        send_req(addr, id);
        recv_resp(name, id, {addr[31:2], 2'b00} ^ 32'hc0de_0000);
        check_flag({name, " refills"}, refill, mem_reads - reads0);
        if (refill == 1) check_flag({name, " pending_rd"}, 1, pend_seen);
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic cold_miss_test();
        read_check("cold miss", A_LINE, 8'h11);
        read_check("line hit", A_LINE, 8'h12);
    endtask

    task automatic word_select_test();
        int i;
        for (i = 0; i < 4; i++) begin
            read_check("word select", A_LINE + 32'(4 * i), 8'h20 + 8'(i));
        end
    endtask

    task automatic conflict_test();
        int reads0;
        reads0 = mem_reads;
        read_check("conflict C", C_ADDR, 8'h30);
        read_check("conflict D", D_ADDR, 8'h31);
        read_check("conflict C", C_ADDR, 8'h32);
        read_check("conflict D", D_ADDR, 8'h33);
        check_flag("conflict total refills", 4, mem_reads - reads0);
    endtask

    task automatic backpressure_test();
        logic [31:0]             addr_q [$];
        logic [`ICACHE_ID_W-1:0] id_q [$];
        int                      reads0;
        int                      k;
        int                      i;
        reads0 = mem_reads;
        k = 0;
        // Completions stay queued while mst_rready is low
        while (mst_arready) begin
            if (k >= 4 * `ICACHE_OSTDREQ) wait_failed("mst_arready to fall");
            addr_q.push_back(A_LINE + 32'(4 * (k % 4)));
            id_q.push_back(8'h40 + 8'(k));
            mst_arvalid = 1'b1;
            mst_araddr  = addr_q[k];
            mst_arid    = id_q[k];
            @(negedge aclk);
            k++;
        end
        mst_arvalid = 1'b0;
        for (i = 0; i < k; i++) begin
            recv_resp("backpressure", id_q[i], addr_q[i] ^ 32'hc0de_0000);
        end
        check_flag("backpressure refills", 0, mem_reads - reads0);
    endtask

    task automatic flush_test();
        int n;
        int i;
        // FENCE.i drops every line
        flush_blocks = 1'b1;
        @(negedge aclk);
        flush_blocks = 1'b0;
        for (i = 0; i < `ICACHE_LINES; i++) model_valid[i] = 1'b0;
        read_check("flush_blocks refill", A_LINE, 8'h60);
        // Two hits queued and then dropped
        send_req(A_LINE, 8'h70);
        send_req(A_LINE + 32'h4, 8'h71);
        n = 0;
        while (!mst_rvalid) begin
            @(negedge aclk);
            n++;
            if (n > TIMEOUT) wait_failed("queued completions");
        end
        // Second hit lands one cycle behind the first
        @(negedge aclk);
        flush_reqs = 1'b1;
        @(negedge aclk);
        flush_reqs = 1'b0;
        check_flag("flush_reqs rvalid", 0, int'(mst_rvalid));
        read_check("after flush_reqs", A_LINE + 32'h8, 8'h72);
    endtask

    initial begin
        aresetn      = 1'b0;
        flush_reqs   = 1'b0;
        flush_blocks = 1'b0;
        mst_arvalid  = 1'b0;
        mst_araddr   = '0;
        mst_arid     = '0;
        mst_arprot   = 3'b100;
        mst_rready   = 1'b0;
        pend_seen    = 0;
        for (int i = 0; i < `ICACHE_LINES; i++) begin
            model_valid[i] = 1'b0;
            model_tag[i]   = '0;
        end
        repeat (16) @(negedge aclk);
        aresetn = 1'b1;
        @(negedge aclk);
        check_flag("reset mst_rvalid", 0, int'(mst_rvalid));
        check_flag("reset mem_arvalid", 0, int'(mem_arvalid));
        check_flag("reset pending_rd", 0, int'(pending_rd));

        cold_miss_test();
        word_select_test();
        conflict_test();
        backpressure_test();
        flush_test();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- tb.f
+incdir+common
common/icache_pkg.sv
common/icache_ifs.sv
hw/icache_scfifo.sv
hw/block_fetcher/icache_block_fetcher.sv
hw/cache_lines/icache_lines.sv
hw/icache_refill.sv
hw/icache_top.sv
testbench/icache_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f tb.f --top-module icache_tb -Mdir obj_dir -o icache_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/icache_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0
